// File: codecConfigTop.f
verilog/codecCfgPkg.sv
verilog/i2cBitTimer.sv
verilog/i2cWriteMaster.sv
verilog/codecInitRom.sv
verilog/codecInitSequencer.sv
verilog/codecConfigTop.sv
sim/i2cSlaveModel.sv
sim/codecConfigTb.sv

// File: Bender.yml
package:
  name: codec_config

sources:
  - verilog/codecCfgPkg.sv
  - verilog/i2cBitTimer.sv
  - verilog/i2cWriteMaster.sv
  - verilog/codecInitRom.sv
  - verilog/codecInitSequencer.sv
  - verilog/codecConfigTop.sv
  - target: simulation
    files:
      - sim/i2cSlaveModel.sv
      - sim/codecConfigTb.sv

// File: sim/codecConfigCases.txt
// Columns: device address byte, 16-bit payload, refused acknowledges before success
// One line per table entry, in table order
34 0000 0
34 001f 0
34 021f 1
34 0479 0
34 0679 0
34 0810 0
34 0a06 0
34 0c00 2
34 0e01 0
34 100e 0
34 1201 0
40 0004 1

// File: sim/codecConfigTb.sv
// Codec configuration testbench
// Replays the cases file against the DUT through an I2C slave model
`default_nettype none
`timescale 1ns/1ns

module codecConfigTb;
	import codecCfgPkg::*;

	typedef struct packed {
		logic       acked;
		logic [7:0] devAddr;
		logic [7:0] payHi;
		logic [7:0] payLo;
	} xferRec_t;

	logic        iCLK;
	logic        iRST_N;
	logic        i2cSclk;
	logic        configDone;
	wire         i2cSdat;
	int          refuseCount;
	logic [24:0] recBits;
	xferRec_t    rec;
	int          startCount;
	logic [15:0] caseMem [0:3*ENTRY_COUNT-1];	// Address, payload, refusals per entry
	int          errors;
	int          testsRun;
	int          testsFailed;
	int          xferExpected;
	int          cycleCount;
	int          cycleLimit;	// Zero until the cases are loaded

	pullup (i2cSdat);	// Bus pull-up

	codecConfigTop i_dut (
		.iCLK       (iCLK),
		.iRST_N     (iRST_N),
		.i2cSclk    (i2cSclk),
		.i2cSdat    (i2cSdat),
		.configDone (configDone)
	);

	i2cSlaveModel uSlave (
		.scl         (i2cSclk),
		.sda         (i2cSdat),
		.refuseCount (refuseCount),
		.xferRec     (recBits),
		.startCount  (startCount)
	);

	always #2 iCLK = ~iCLK;	// 4 ns period

	////////////////////////////////////////////////////////////
	// Run limit
	always @(posedge iCLK)
	begin
		cycleCount = cycleCount + 1;
		if ((cycleLimit > 0) && (cycleCount >= cycleLimit))
		begin
			if (startCount < xferExpected)
				$display("Timeout: %0d of %0d transfers seen, the DUT hangs",
					startCount, xferExpected);
			else
				$display("Timeout: all transfers seen but configDone never rose");
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic expectHex(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %0h, expected %0h", name, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic checkIdle();
		expectHex("i2cSclk", i2cSclk, 1);
		expectHex("i2cSdat", i2cSdat, 1);	// Released and pulled high
		expectHex("configDone", configDone, 0);
	endtask

	task automatic closeTest(input string name, input int errBefore);
		testsRun = testsRun + 1;
		if (errors == errBefore)
			$display("Test %s: pass", name);
		else
		begin
			testsFailed = testsFailed + 1;
			$display("Test %s: FAIL with %0d errors", name, errors - errBefore);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Idle bus during reset and just after
	task automatic resetAndCheckIdle(input int unsigned rstExtra);
		int errBefore;

		errBefore = errors;
		repeat (16 + rstExtra)
		begin
			@(negedge iCLK);
			checkIdle();
		end
		@(posedge iCLK);
		#1 iRST_N = 1'b1;
		@(negedge iCLK);
		checkIdle();
		closeTest("idle after reset", errBefore);
	endtask

	// One test per table entry with its retries
	task automatic replayEntries();
		int e;
		int k;
		int refusals;
		int errBefore;

		for (e = 0; e < ENTRY_COUNT; e++)
		begin
			errBefore = errors;
			refusals  = caseMem[3*e+2];
			for (k = 0; k <= refusals; k++)
			begin
				refuseCount = refusals - k;
				@(uSlave.xferSeen);
				@(negedge iCLK);
				rec = recBits;
				expectHex("address byte", rec.devAddr, caseMem[3*e][7:0]);
				expectHex("address rule", rec.devAddr,
					(e == ENTRY_COUNT - 1) ? 8'h40 : 8'h34);	// Only the last entry is video
				expectHex("payload high byte", rec.payHi, caseMem[3*e+1][15:8]);
				expectHex("payload low byte", rec.payLo, caseMem[3*e+1][7:0]);
				expectHex("acked", rec.acked, (k == refusals));	// Ack bits as seen on the bus
				expectHex("configDone", configDone, 0);	// Not before the last stop
			end
			closeTest($sformatf("entry %0d", e), errBefore);
		end
	endtask

	// Done level and a quiet bus afterwards
	task automatic watchCompletion();
		int errBefore;
		int startsAtDone;

		errBefore = errors;
		while (configDone !== 1'b1)
			@(negedge iCLK);
		startsAtDone = startCount;
		repeat (1000)
		begin
			@(negedge iCLK);
			expectHex("configDone", configDone, 1);
		end
		expectHex("startCount", startCount, startsAtDone);
		closeTest("completion", errBefore);
	endtask

	task automatic compareTransferCount();
		int errBefore;

		errBefore = errors;
		expectHex("transfer count", startCount, xferExpected);
		closeTest("transfer count", errBefore);
	endtask

	////////////////////////////////////////////////////////////
	initial
	begin
		int          e;
		int unsigned seed;
		int unsigned rstExtra;
		logic        loadBad;

		iCLK        = 1'b0;
		iRST_N      = 1'b0;
		refuseCount = 0;
		errors      = 0;
		testsRun    = 0;
		testsFailed = 0;
		cycleCount  = 0;
		cycleLimit  = 0;
		loadBad     = 1'b0;
		seed        = 32'h602dd770;
		void'($urandom(seed));
		rstExtra    = $urandom % 4;	// Reset release jitter

		$readmemh("sim/codecConfigCases.txt", caseMem);
		xferExpected = ENTRY_COUNT;
		for (e = 0; e < 3*ENTRY_COUNT; e++)
			if ($isunknown(caseMem[e]))
				loadBad = 1'b1;
		for (e = 0; e < ENTRY_COUNT; e++)
			xferExpected = xferExpected + caseMem[3*e+2];

		if (loadBad)
		begin
			$display("Cases file sim/codecConfigCases.txt missing or incomplete");
			errors = errors + 1;
		end
		else
		begin
			cycleLimit = 2 * xferExpected * 29 * 4 * QUARTER_DIV + 2000;
			resetAndCheckIdle(rstExtra);
			replayEntries();
			watchCompletion();
			compareTransferCount();
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			testsRun, testsRun - testsFailed, testsFailed, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/i2cSlaveModel.sv
// I2C slave model
// Records each write transfer, refuses the address byte on request
`default_nettype none
`timescale 1ns/1ns

module i2cSlaveModel (
	input  wire         scl,
	inout  wire         sda,
	input  int          refuseCount,	// NACK this transfer when non-zero
	output logic [24:0] xferRec,	// Acked flag, address, payload
	output int          startCount
);
	event xferSeen;	// Fires on each stop

	logic        active;	// Between start and stop
	logic        ackDrive;
	logic        refused;
	logic        nackSeen;	// Some ack bit was high on the bus
	logic [7:0]  shiftIn;
	logic [23:0] bytesIn;
	int          bitPos;	// 0..7 data, 8 ack slot
	int          byteNum;

	assign sda = ackDrive ? 1'b0 : 1'bz;	// Open drain

	initial
	begin
		active     = 1'b0;
		ackDrive   = 1'b0;
		refused    = 1'b0;
		nackSeen   = 1'b0;
		startCount = 0;
		xferRec    = '0;
	end

	////////////////////////////////////////////////////////////
	// Start and stop seen as SDA moving while SCL high
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			active     = 1'b1;
			bitPos     = 0;
			byteNum    = 0;
			refused    = 1'b0;
			nackSeen   = 1'b0;
			bytesIn    = '0;
			startCount = startCount + 1;
		end
	end

	always @(posedge sda)
	begin
		if ((scl === 1'b1) && active)
		begin
			active  = 1'b0;
			xferRec = {!nackSeen, bytesIn};
			-> xferSeen;
		end
	end

	////////////////////////////////////////////////////////////
	// Bits in on SCL rise
	always @(posedge scl)
	begin
		if (active)
		begin
			if (bitPos < 8)
				shiftIn = {shiftIn[6:0], (sda === 1'b1)};	// MSB first
			else if ((bitPos == 8) && (sda !== 1'b0))
				nackSeen = 1'b1;	// Ack bit as the bus shows it
			bitPos = bitPos + 1;
		end
	end

	// Acknowledge driven and released on SCL fall
	always @(negedge scl)
	begin
		if (active)
		begin
			if (bitPos == 8)
			begin
				bytesIn = {bytesIn[15:0], shiftIn};
				if ((byteNum == 0) && (refuseCount != 0))
					refused = 1'b1;	// Ignore the rest once refused
				ackDrive = !refused;
			end
			else if (bitPos == 9)
			begin
				ackDrive = 1'b0;
				bitPos   = 0;
				byteNum  = byteNum + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/codecConfigTop.sv
// Codec configuration top
// Timer, sequencer, table and I2C write master on the shared bus
`default_nettype none
`timescale 1ns/1ns

module codecConfigTop (
	input  logic iCLK,
	input  logic iRST_N,
	output logic i2cSclk,
	inout  wire  i2cSdat,
	output logic configDone
);
	import codecCfgPkg::*;

	logic        qtrTick;	// Quarter-bit enable
	logic        xferGo;
	logic        xferDone;
	logic        xferAck;
	logic        sdaLow;
	logic        sdaIn;
	i2cWord_t    xferWord;
	entryIdx_t   entryIndex;
	cfgPayload_u payload;

	// Open-drain SDA, pulled up on the board
	assign i2cSdat = sdaLow ? 1'b0 : 1'bz;
	assign sdaIn   = i2cSdat;

	////////////////////////////////////////////////////////////
	i2cBitTimer uTimer (
		.iCLK    (iCLK),
		.iRST_N  (iRST_N),
		.qtrTick (qtrTick)
	);

	codecInitRom uRom (
		.entryIndex (entryIndex),
		.payload    (payload)
	);

	codecInitSequencer uSeq (
		.iCLK       (iCLK),
		.iRST_N     (iRST_N),
		.entryIndex (entryIndex),
		.payload    (payload),
		.xferGo     (xferGo),
		.xferWord   (xferWord),
		.xferDone   (xferDone),
		.xferAck    (xferAck),
		.configDone (configDone)
	);

	i2cWriteMaster uMaster (
		.iCLK     (iCLK),
		.iRST_N   (iRST_N),
		.qtrTick  (qtrTick),
		.xferGo   (xferGo),
		.xferWord (xferWord),
		.xferDone (xferDone),
		.xferAck  (xferAck),
		.sclk     (i2cSclk),	// Push-pull
		.sdaLow   (sdaLow),
		.sdaIn    (sdaIn)
	);

endmodule

`default_nettype wire

// File: verilog/codecInitSequencer.sv
// Codec init sequencer
// Walks the table, starts one transfer per entry, retries on NACK
`default_nettype none
`timescale 1ns/1ns

module codecInitSequencer (
	input  logic                     iCLK,
	input  logic                     iRST_N,
	output codecCfgPkg::entryIdx_t   entryIndex,
	input  codecCfgPkg::cfgPayload_u payload,
	output logic                     xferGo,
	output codecCfgPkg::i2cWord_t    xferWord,
	input  logic                     xferDone,
	input  logic                     xferAck,
	output logic                     configDone
);
	import codecCfgPkg::*;

	enum logic [1:0] {
		ST_LOAD,	// Build word, raise go
		ST_WAIT,	// Transfer in flight
		ST_NEXT	// Acked, step the index
	} seqState;

	logic tableEnd;

	assign tableEnd = (entryIndex == entryIdx_t'(ENTRY_COUNT));

	////////////////////////////////////////////////////////////
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			seqState   <= ST_LOAD;
			entryIndex <= '0;
			xferGo     <= 1'b0;
			configDone <= 1'b0;
		end
		else
		begin
			if (tableEnd)
				configDone <= 1'b1;	// Held until reset
			case (seqState)
				ST_LOAD:
				begin
					if (!tableEnd)
					begin
						xferGo   <= 1'b1;
						seqState <= ST_WAIT;
					end
				end
				ST_WAIT:
				begin
					if (xferDone)
					begin
						xferGo   <= 1'b0;
						seqState <= xferAck ? ST_NEXT : ST_LOAD;	// NACK resends same entry
					end
				end
				ST_NEXT:
				begin
					entryIndex <= entryIndex + entryIdx_t'(1);
					seqState   <= ST_LOAD;
				end
				default: seqState <= ST_LOAD;
			endcase
		end
	end

	// Word for the master, address picked by index
	always_ff @(posedge iCLK)
	begin
		if (seqState == ST_LOAD)
		begin
			xferWord.devAddr <= (entryIndex < FIRST_VIDEO_ENTRY) ? CODEC_ADDR : VIDEO_ADDR;
			xferWord.payload <= payload;
		end
	end

	////////////////////////////////////////////////////////////
	indexInRange: assert property (@(posedge iCLK) disable iff (!iRST_N)
		entryIndex <= entryIdx_t'(ENTRY_COUNT))
		else $error("Table index past ENTRY_COUNT");

endmodule

`default_nettype wire

// File: verilog/codecInitRom.sv
// Codec init table
// Fixed configuration writes, answered combinationally per entry
`default_nettype none
`timescale 1ns/1ns

module codecInitRom (
	input  codecCfgPkg::entryIdx_t   entryIndex,
	output codecCfgPkg::cfgPayload_u payload
);
	import codecCfgPkg::*;

	// Codec view, 7-bit register and 9-bit value
	function automatic cfgPayload_u codecWr(input logic [6:0] regAddr, input logic [8:0] regData);
		cfgPayload_u p;
		p.codec.regAddr = regAddr;
		p.codec.regData = regData;
		return p;
	endfunction

	// Video decoder view, byte sub-address and byte value
	function automatic cfgPayload_u videoWr(input logic [7:0] subAddr, input logic [7:0] subData);
		cfgPayload_u p;
		p.video.subAddr = subAddr;
		p.video.subData = subData;
		return p;
	endfunction

	always_comb
	begin
		case (entryIndex)
			4'd0:    payload = codecWr(7'h00, 9'h000);	// Null write
			4'd1:    payload = codecWr(7'h00, 9'h01f);	// Left line-in, high gain
			4'd2:    payload = codecWr(7'h01, 9'h01f);	// Right line-in
			4'd3:    payload = codecWr(7'h02, 9'h079);	// Left headphone volume
			4'd4:    payload = codecWr(7'h03, 9'h079);	// Right headphone volume
			4'd5:    payload = codecWr(7'h04, 9'h010);	// Line to ADC, DAC on, no bypass
			4'd6:    payload = codecWr(7'h05, 9'h006);	// Digital path, de-emphasis
			4'd7:    payload = codecWr(7'h06, 9'h000);	// Power, all blocks on
			4'd8:    payload = codecWr(7'h07, 9'h001);	// Left-justified, slave mode
			4'd9:    payload = codecWr(7'h08, 9'h00e);	// 8 kHz sample rate
			4'd10:   payload = codecWr(7'h09, 9'h001);	// Activate
			4'd11:   payload = videoWr(8'h00, 8'h04);	// Decoder input select
			default: payload = '0;	// Outside the table
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/i2cWriteMaster.sv
// I2C write master
// Sends start, three bytes with acknowledge sampling, then stop
`default_nettype none
`timescale 1ns/1ns

module i2cWriteMaster (
	input  logic                 iCLK,
	input  logic                 iRST_N,
	input  logic                 qtrTick,
	input  logic                 xferGo,
	input  codecCfgPkg::i2cWord_t xferWord,
	output logic                 xferDone,
	output logic                 xferAck,
	output logic                 sclk,
	output logic                 sdaLow,
	input  logic                 sdaIn
);
	import codecCfgPkg::*;

	i2cPhase_t                   phase;
	logic [1:0]                  qtr;	// Quarter within the bit slot
	logic [2:0]                  bitCnt;	// Data bit within the byte
	logic [1:0]                  byteCnt;
	logic [$bits(i2cWord_t)-1:0] shiftReg;
	logic                        ackOk;	// Cleared by any NACK
	logic                        sclkDec;
	logic                        sdaLowDec;
	logic                        sclHigh;	// Middle two quarters of a bit slot

	assign sclHigh = (qtr == 2'd1) || (qtr == 2'd2);
	assign xferAck = ackOk;	// Valid with xferDone

	////////////////////////////////////////////////////////////
	// Phase control, one step per quarter tick
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			phase    <= PH_IDLE;
			qtr      <= 2'd0;
			bitCnt   <= 3'd0;
			byteCnt  <= 2'd0;
			ackOk    <= 1'b0;
			xferDone <= 1'b0;
		end
		else
		begin
			xferDone <= 1'b0;
			if (qtrTick)
			begin
				if (phase != PH_IDLE)
					qtr <= qtr + 2'd1;
				case (phase)
					PH_IDLE:
					begin
						if (xferGo)
						begin
							phase   <= PH_START;
							qtr     <= 2'd0;
							bitCnt  <= 3'd0;
							byteCnt <= 2'd0;
							ackOk   <= 1'b1;	// Assume success until a NACK
						end
					end
					PH_START:
					begin
						if (qtr == 2'd3)
							phase <= PH_BIT;
					end
					PH_BIT:
					begin
						if (qtr == 2'd3)
						begin
							bitCnt <= bitCnt + 3'd1;	// Wraps to 0 after bit 7
							if (bitCnt == 3'd7)
								phase <= PH_ACK;
						end
					end
					PH_ACK:
					begin
						// Sample in the SCL high half
						if ((qtr == 2'd1) && sdaIn)
							ackOk <= 1'b0;
						if (qtr == 2'd3)
						begin
							if (byteCnt == 2'd2)
								phase <= PH_STOP;	// Third byte done
							else
							begin
								byteCnt <= byteCnt + 2'd1;
								phase   <= PH_BIT;
							end
						end
					end
					PH_STOP:
					begin
						if (qtr == 2'd3)
						begin
							phase    <= PH_IDLE;
							xferDone <= 1'b1;
						end
					end
					default: phase <= PH_IDLE;
				endcase
			end
		end
	end

	// Data shifter, MSB out first
	always_ff @(posedge iCLK)
	begin
		if (qtrTick)
		begin
			if ((phase == PH_IDLE) && xferGo)
				shiftReg <= xferWord;
			else if ((phase == PH_BIT) && (qtr == 2'd3))
				shiftReg <= shiftReg << 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Line levels per phase and quarter
	always_comb
	begin
		sclkDec   = 1'b1;	// Idle bus
		sdaLowDec = 1'b0;
		case (phase)
			PH_START:
			begin
				sclkDec   = (qtr != 2'd3);
				sdaLowDec = (qtr != 2'd0);	// SDA falls with SCL high
			end
			PH_BIT:
			begin
				sclkDec   = sclHigh;
				sdaLowDec = ~shiftReg[$bits(i2cWord_t)-1];
			end
			PH_ACK:
			begin
				sclkDec   = sclHigh;
				sdaLowDec = 1'b0;	// Released for the slave
			end
			PH_STOP:
			begin
				sclkDec   = (qtr != 2'd0);
				sdaLowDec = (qtr < 2'd2);	// SDA rises with SCL high
			end
			default: ;
		endcase
	end

	// Registered pins, no decode glitches
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			sclk   <= 1'b1;
			sdaLow <= 1'b0;
		end
		else
		begin
			sclk   <= sclkDec;
			sdaLow <= sdaLowDec;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	doneOnePulse: assert property (@(posedge iCLK) disable iff (!iRST_N)
		xferDone |=> !xferDone)
		else $error("xferDone longer than one cycle");

	// Pins lag the phase by one cycle
	sdaStableHigh: assert property (@(posedge iCLK) disable iff (!iRST_N)
		$changed(sdaLow) |-> (!sclk && !$past(sclk)) ||
			($past(phase) inside {PH_START, PH_STOP}))
		else $error("SDA moved while SCL high outside start or stop");

endmodule

`default_nettype wire

// File: verilog/i2cBitTimer.sv
// I2C bit timer
// Free-running divider giving one enable pulse per quarter SCL period
`default_nettype none
`timescale 1ns/1ns

module i2cBitTimer (
	input  logic iCLK,
	input  logic iRST_N,
	output logic qtrTick
);
	import codecCfgPkg::*;

	logic [QTR_CNT_W-1:0] qtrCount;	// Cycles within the current quarter
	logic                 qtrLast;

	assign qtrLast = (qtrCount == QTR_CNT_W'(QUARTER_DIV - 1));

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			qtrCount <= '0;
			qtrTick  <= 1'b0;
		end
		else
		begin
			if (qtrLast)
			begin
				qtrCount <= '0;	// Wrap
				qtrTick  <= 1'b1;
			end
			else
			begin
				qtrCount <= qtrCount + 1'b1;
				qtrTick  <= 1'b0;	// Pulse is one cycle wide
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/codecCfgPkg.sv
// Codec configuration package
// Bus timing, table size, device addresses and the I2C transfer word
`default_nettype none

package codecCfgPkg;

	////////////////////////////////////////////////////////////
	// Bus timing
	localparam int unsigned QUARTER_DIV = 125;	// 50 MHz clock, 100 kHz SCL, four quarters
	localparam int unsigned QTR_CNT_W = $clog2(QUARTER_DIV);

	////////////////////////////////////////////////////////////
	// Table and targets
	localparam int unsigned ENTRY_COUNT = 12;	// Codec writes plus one video write

	typedef logic [3:0] entryIdx_t;	// Table index, also holds ENTRY_COUNT

	localparam logic [7:0] CODEC_ADDR = 8'h34;	// Audio codec, write
	localparam logic [7:0] VIDEO_ADDR = 8'h40;	// Video decoder, write
	localparam entryIdx_t FIRST_VIDEO_ENTRY = 4'd11;

	////////////////////////////////////////////////////////////
	// Payload views
	// Codec packs a 7-bit register number above a 9-bit value
	typedef struct packed {
		logic [6:0] regAddr;
		logic [8:0] regData;
	} codecReg_t;

	// Video decoder uses plain sub-address and data bytes
	typedef struct packed {
		logic [7:0] subAddr;
		logic [7:0] subData;
	} videoReg_t;

	typedef union packed {
		codecReg_t codec;
		videoReg_t video;
	} cfgPayload_u;

	// Sent MSB first: address byte, then the two payload bytes
	typedef struct packed {
		logic [7:0]  devAddr;
		cfgPayload_u payload;
	} i2cWord_t;

	// Write master bus states
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_START,
		PH_BIT,
		PH_ACK,
		PH_STOP
	} i2cPhase_t;

endpackage

`default_nettype wire
